// ==== sim.f ====
+incdir+testbench
source/cache_pkg.sv
source/mem_msg_pkg.sv
source/cache_ctrl_if.sv
source/burst_if.sv
source/cache_fsm.sv
source/tag_store.sv
source/data_store.sv
source/line_burst.sv
source/cache_top.sv
testbench/tb_clock.sv
testbench/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/cache_tb_tasks.svh ====
/* Tasks of cache_tb. Callers start 1 ns after a rising edge and end there too */
`ifndef CACHE_TB_TASKS_SVH
`define CACHE_TB_TASKS_SVH

// Reference model of the cache contents
logic             ref_valid [2][8];
logic             ref_dirty [2][8];
logic             ref_ns    [2][8];
cache_pkg::tag_t  ref_tag   [2][8];
cache_pkg::word_t ref_data  [2][8][4];
logic             ref_lru   [8];
cache_pkg::word_t ref_mem   [MEM_WORDS];

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic in_fail_range(input cache_pkg::addr_t a);
  return (a >= FAIL_LO) && (a <= FAIL_HI);
endfunction

function automatic cache_pkg::line_t mem_line(input cache_pkg::addr_t a);
  return {mem[{a[13:4], 2'd3}], mem[{a[13:4], 2'd2}], mem[{a[13:4], 2'd1}],
          mem[{a[13:4], 2'd0}]};
endfunction

function automatic cache_pkg::line_t ref_mem_line(input cache_pkg::addr_t a);
  return {ref_mem[{a[13:4], 2'd3}], ref_mem[{a[13:4], 2'd2}], ref_mem[{a[13:4], 2'd1}],
          ref_mem[{a[13:4], 2'd0}]};
endfunction

task automatic init_memory();
  for (int a = 0; a < MEM_WORDS; a++) begin
    mem[a]     = lcg_next(32'(a));
    ref_mem[a] = mem[a];
  end
  for (int s = 0; s < 8; s++) begin
    ref_lru[s] = 1'b0;
    for (int w = 0; w < 2; w++) begin
      ref_valid[w][s] = 1'b0;
      ref_dirty[w][s] = 1'b0;
    end
  end
endtask

// ------------------------------
// Compare tasks
task automatic check_word(input string what, input cache_pkg::word_t got,
                          input cache_pkg::word_t exp);
  if (got !== exp) begin
    errors++;
    $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    errors++;
    $display("FAILED %0t: %s got %b expected %b", $time, what, got, exp);
  end
endtask

task automatic check_line(input string what, input cache_pkg::line_t got,
                          input cache_pkg::line_t exp);
  if (got !== exp) begin
    errors++;
    $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

// Predicts one request and updates the model
task automatic predict(input logic write, input logic ns, input cache_pkg::addr_t a,
                       input cache_pkg::word_t data, output cache_pkg::word_t exp_data,
                       output logic exp_denied);
  cache_pkg::index_t    idx;
  cache_pkg::tag_t      tag;
  cache_pkg::word_sel_t ws;
  cache_pkg::way_t      way;
  logic                 hit;
  logic                 false_hit;
  idx        = a[6:4];
  tag        = a[31:7];
  ws         = a[3:2];
  hit        = 1'b0;
  false_hit  = 1'b0;
  way        = 1'b0;
  exp_data   = '0;
  exp_denied = 1'b0;
  for (int w = 0; w < 2; w++) begin
    if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
      if (ref_ns[w][idx] == ns) begin
        hit = 1'b1;
        way = cache_pkg::way_t'(w);
      end else begin
        false_hit = 1'b1;
      end
    end
  end
  if (!hit && false_hit) begin
    exp_denied = 1'b1;
    return;
  end
  if (!hit) begin
    way = ref_lru[idx];
    // Dirty victim goes back to memory and stays in the set as it is
    if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
      for (int i = 0; i < 4; i++)
        ref_mem[{ref_tag[way][idx][6:0], idx, 2'(i)}] = ref_data[way][idx][i];
    end
    if (in_fail_range({a[31:4], 4'h0})) begin
      exp_denied = 1'b1;
      return;
    end
    for (int i = 0; i < 4; i++)
      ref_data[way][idx][i] = ref_mem[{a[13:4], 2'(i)}];
    ref_valid[way][idx] = 1'b1;
    ref_dirty[way][idx] = 1'b0;
    ref_tag[way][idx]   = tag;
    ref_ns[way][idx]    = ns;
  end
  if (write) begin
    ref_data[way][idx][ws] = data;
    ref_dirty[way][idx]    = 1'b1;
  end else begin
    exp_data = ref_data[way][idx][ws];
  end
  ref_lru[idx] = ~way;
endtask

// One request through the cache port with the response held for hold cycles
task automatic send_request(input logic write, input logic ns, input cache_pkg::addr_t a,
                            input cache_pkg::word_t data, input int hold,
                            output cache_pkg::word_t got_data, output logic got_denied,
                            output int latency);
  logic accepted;
  accepted  = 1'b0;
  latency   = 0;
  issued++;
  req_val   = 1'b1;
  req_write = write;
  req_ns    = ns;
  req_addr  = a;
  req_data  = data;
  do begin
    accepted = req_rdy;
    @(posedge clk);
    #1;
  end while (!accepted);
  req_val = 1'b0;
  while (!resp_val) begin
    @(posedge clk);
    #1;
    latency++;
  end
  got_data   = resp_data;
  got_denied = resp_denied;
  for (int i = 0; i < hold; i++) begin
    @(posedge clk);
    #1;
    check_flag("resp_val held", resp_val, 1'b1);
    check_word("resp_data held", resp_data, got_data);
    check_flag("resp_denied held", resp_denied, got_denied);
    check_flag("req_rdy while response pending", req_rdy, 1'b0);
  end
  resp_rdy = 1'b1;
  @(posedge clk);
  #1;
  resp_rdy = 1'b0;
endtask

task automatic access_and_check(input logic write, input logic ns, input cache_pkg::addr_t a,
                                input cache_pkg::word_t data, input int hold,
                                output int latency);
  cache_pkg::word_t exp_data;
  cache_pkg::word_t got_data;
  logic             exp_denied;
  logic             got_denied;
  predict(write, ns, a, data, exp_data, exp_denied);
  send_request(write, ns, a, data, hold, got_data, got_denied, latency);
  check_word($sformatf("data at %h", a), got_data, exp_data);
  check_flag($sformatf("denied at %h", a), got_denied, exp_denied);
endtask

// ------------------------------
// Directed tests
task automatic read_miss_then_hit();
  int lat;
  access_and_check(1'b0, 1'b0, 32'h0000_0100, '0, 0, lat);
  access_and_check(1'b0, 1'b0, 32'h0000_0104, '0, 0, lat);
  if (lat != 3) begin
    errors++;
    $display("FAILED %0t: hit latency %0d expected 3", $time, lat);
  end
endtask

task automatic write_allocate();
  int lat;
  access_and_check(1'b1, 1'b0, 32'h0000_0214, 32'hcafe_0001, 0, lat);
  access_and_check(1'b0, 1'b0, 32'h0000_0214, '0, 0, lat);
  access_and_check(1'b0, 1'b0, 32'h0000_0210, '0, 0, lat);
  access_and_check(1'b0, 1'b0, 32'h0000_0218, '0, 0, lat);
endtask

task automatic dirty_eviction();
  int lat;
  access_and_check(1'b1, 1'b0, 32'h0000_0048, 32'hbeef_0002, 0, lat);
  access_and_check(1'b0, 1'b0, 32'h0000_0440, '0, 0, lat);
  access_and_check(1'b0, 1'b0, 32'h0000_0840, '0, 0, lat);
  check_line("written back line", mem_line(32'h0000_0040), ref_mem_line(32'h0000_0040));
  access_and_check(1'b0, 1'b0, 32'h0000_0048, '0, 0, lat);
endtask

task automatic ns_false_hit();
  int lat;
  access_and_check(1'b0, 1'b0, 32'h0000_0300, '0, 0, lat);
  access_and_check(1'b0, 1'b1, 32'h0000_0300, '0, 0, lat);
  access_and_check(1'b1, 1'b1, 32'h0000_0300, 32'h1234_5678, 0, lat);
  access_and_check(1'b0, 1'b0, 32'h0000_0300, '0, 0, lat);
  check_flag("original NS still hits", lat == 3, 1'b1);
endtask

task automatic refill_fail();
  int lat;
  access_and_check(1'b0, 1'b0, 32'h0000_3020, '0, 0, lat);
  access_and_check(1'b0, 1'b0, 32'h0000_3024, '0, 0, lat);
  check_flag("failed line misses again", lat > 3, 1'b1);
endtask

task automatic backpressure();
  int lat;
  logic wr;
  logic ns;
  cache_pkg::addr_t a;
  access_and_check(1'b0, 1'b0, 32'h0000_0104, '0, 5, lat);
  access_and_check(1'b1, 1'b0, 32'h0000_0104, 32'h0bad_f00d, 4, lat);
  stall_en = 1'b1;
  for (int i = 0; i < 40; i++) begin
    stim_rng = lcg_next(stim_rng);
    wr = stim_rng[4];
    ns = (stim_rng[10:8] == 3'd0);
    a  = stim_rng & 32'h0000_0ffc;
    stim_rng = lcg_next(stim_rng);
    access_and_check(wr, ns, a, stim_rng, i % 3, lat);
  end
  stall_en = 1'b0;
endtask

`endif

// ==== testbench/cache_tb.sv ====
/* Directed tests of the data cache against a reference model. Memory model
   holds 4096 words, answers in 0 to 3 cycles and fails refills in 0x3000-0x30ff */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  localparam logic [31:0] SEED      = 32'h63823bf5;
  localparam int          MEM_WORDS = 4096;
  localparam int          TIMEOUT_PER_REQ = 200;
  localparam int          TIMEOUT_MARGIN  = 100;
  localparam logic [31:0] FAIL_LO   = 32'h0000_3000;
  localparam logic [31:0] FAIL_HI   = 32'h0000_30ff;

  logic             clk;
  logic             reset;
  logic             req_val;
  logic             req_rdy;
  logic             req_write;
  logic             req_ns;
  cache_pkg::addr_t req_addr;
  cache_pkg::word_t req_data;
  logic             resp_val;
  logic             resp_rdy;
  cache_pkg::word_t resp_data;
  logic             resp_denied;
  logic             mem_req_val;
  logic             mem_req_rdy;
  logic             mem_req_write;
  cache_pkg::addr_t mem_req_addr;
  cache_pkg::word_t mem_req_data;
  logic             mem_resp_val;
  cache_pkg::word_t mem_resp_data;
  logic             mem_resp_fail;

  int errors;
  int issued;
  int cycles;

  // Memory model state
  cache_pkg::word_t mem [MEM_WORDS];
  logic             pend;
  int               pend_delay;
  cache_pkg::addr_t pend_addr;
  cache_pkg::word_t pend_data;
  logic             pend_write;
  logic             xfer;
  cache_pkg::addr_t xfer_addr;
  cache_pkg::word_t xfer_data;
  logic             xfer_write;
  logic             stall_en;
  logic [31:0]      mem_rng;
  logic [31:0]      stim_rng;

  tb_clock clock_i (
    .clk   (clk),
    .reset (reset)
  );

  cache_top dut_i (
    .clk, .reset,
    .req_val, .req_rdy, .req_write, .req_ns, .req_addr, .req_data,
    .resp_val, .resp_rdy, .resp_data, .resp_denied,
    .mem_req_val, .mem_req_rdy, .mem_req_write, .mem_req_addr, .mem_req_data,
    .mem_resp_val, .mem_resp_data, .mem_resp_fail
  );

  `include "cache_tb_tasks.svh"

  // ------------------------------
  // Memory model
  always @(posedge clk) begin
    if (!reset && xfer) begin
      mem_rng    = lcg_next(mem_rng);
      pend       = 1'b1;
      pend_delay = int'(mem_rng[17:16]);
      pend_addr  = xfer_addr;
      pend_data  = xfer_data;
      pend_write = xfer_write;
    end
    #1;
    mem_resp_val  = 1'b0;
    mem_resp_fail = 1'b0;
    mem_resp_data = '0;
    if (reset) begin
      pend = 1'b0;
    end else if (pend) begin
      if (pend_delay == 0) begin
        pend         = 1'b0;
        mem_resp_val = 1'b1;
        if (pend_write) begin
          mem[pend_addr[13:2]] = pend_data;
        end else begin
          mem_resp_data = mem[pend_addr[13:2]];
          mem_resp_fail = in_fail_range(pend_addr);
        end
      end else begin
        pend_delay--;
      end
    end
    // Random stalls on the request side
    mem_rng     = lcg_next(mem_rng);
    mem_req_rdy = !stall_en || (mem_rng[29:28] != 2'b00);
    // Request that transfers at the coming edge
    xfer       = mem_req_val && mem_req_rdy;
    xfer_addr  = mem_req_addr;
    xfer_data  = mem_req_data;
    xfer_write = mem_req_write;
  end

  // Run limit grows with every issued request
  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_PER_REQ * issued + TIMEOUT_MARGIN) begin
      $display("Timeout: the cache stopped responding after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    errors      = 0;
    issued      = 0;
    cycles      = 0;
    pend        = 1'b0;
    xfer        = 1'b0;
    stall_en    = 1'b0;
    mem_rng     = SEED;
    stim_rng    = lcg_next(SEED);
    req_val     = 1'b0;
    req_write   = 1'b0;
    req_ns      = 1'b0;
    req_addr    = '0;
    req_data    = '0;
    resp_rdy    = 1'b0;
    mem_req_rdy = 1'b1;
    mem_resp_val  = 1'b0;
    mem_resp_data = '0;
    mem_resp_fail = 1'b0;
    init_memory();
    @(negedge reset);
    @(posedge clk);
    #1;
    read_miss_then_hit();
    write_allocate();
    dirty_eviction();
    ns_false_hit();
    refill_fail();
    backpressure();
    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
/* 10 ns clock. Reset is held high for the first 3 rising edges */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/cache_top.sv ====
/* Top of the blocking data cache. Cache side and memory side use
   val/rdy request handshakes, every memory request gets one response */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  logic             clk,
  input  logic             reset,
  input  logic             req_val,
  output logic             req_rdy,
  input  logic             req_write,
  input  logic             req_ns,
  input  cache_pkg::addr_t req_addr,
  input  cache_pkg::word_t req_data,
  output logic             resp_val,
  input  logic             resp_rdy,
  output cache_pkg::word_t resp_data,
  output logic             resp_denied,
  output logic             mem_req_val,
  input  logic             mem_req_rdy,
  output logic             mem_req_write,
  output cache_pkg::addr_t mem_req_addr,
  output cache_pkg::word_t mem_req_data,
  input  logic             mem_resp_val,
  input  cache_pkg::word_t mem_resp_data,
  input  logic             mem_resp_fail
);

  cache_ctrl_if ctrl_bus ();
  burst_if      burst_bus ();

  cache_fsm fsm_i (
    .clk, .reset,
    .req_val, .req_write, .req_ns, .req_addr, .req_data, .req_rdy,
    .resp_val, .resp_rdy, .resp_data, .resp_denied,
    .ctrl  (ctrl_bus.fsm),
    .burst (burst_bus.fsm)
  );

  tag_store tags_i (
    .clk, .reset,
    .ctrl (ctrl_bus.tags)
  );

  // Refill line comes straight from the burst buffer
  data_store data_i (
    .clk,
    .ctrl    (ctrl_bus.data),
    .line_in (burst_bus.line_in)
  );

  line_burst burst_i (
    .clk, .reset,
    .burst (burst_bus.burst),
    .mem_req_val, .mem_req_rdy, .mem_req_write, .mem_req_addr, .mem_req_data,
    .mem_resp_val, .mem_resp_data, .mem_resp_fail
  );

endmodule

`default_nettype wire

// ==== source/line_burst.sv ====
/* Moves one line as four word beats, one request outstanding at a time.
   Beat n goes out only after the response to beat n-1 */
`timescale 1ns/1ps
`default_nettype none

module line_burst (
  input  logic             clk,
  input  logic             reset,
  burst_if.burst           burst,
  output logic             mem_req_val,
  input  logic             mem_req_rdy,
  output logic             mem_req_write,
  output cache_pkg::addr_t mem_req_addr,
  output cache_pkg::word_t mem_req_data,
  input  logic             mem_resp_val,
  input  cache_pkg::word_t mem_resp_data,
  input  logic             mem_resp_fail
);

  mem_msg_pkg::beat_t   beat;
  mem_msg_pkg::mem_op_e op_q;
  cache_pkg::addr_t     base_q;
  cache_pkg::line_t     line_buf;
  logic                 waiting;
  logic                 resp_go;
  logic                 last_beat;

  assign resp_go   = waiting && mem_resp_val;
  assign last_beat = (beat == mem_msg_pkg::beat_t'(mem_msg_pkg::BURST_BEATS - 1));

  // ------------------------------
  // Beat sequencing
  always_ff @(posedge clk) begin
    if (reset) begin
      beat        <= '0;
      mem_req_val <= 1'b0;
      waiting     <= 1'b0;
      burst.done  <= 1'b0;
      burst.fail  <= 1'b0;
    end else begin
      burst.done <= 1'b0;
      if (burst.start) begin
        beat        <= '0;
        mem_req_val <= 1'b1;
        burst.fail  <= 1'b0;
      end else if (mem_req_val && mem_req_rdy) begin
        mem_req_val <= 1'b0;
        waiting     <= 1'b1;
      end else if (resp_go) begin
        waiting <= 1'b0;
        // Any failed refill beat spoils the line
        if (op_q == mem_msg_pkg::READ && mem_resp_fail) burst.fail <= 1'b1;
        if (last_beat) burst.done <= 1'b1;
        else begin
          beat        <= beat + 1'b1;
          mem_req_val <= 1'b1;
        end
      end
    end
  end

  // Line shifts one word per response, out at the bottom and in at the top
  always_ff @(posedge clk) begin
    if (burst.start) begin
      op_q     <= burst.op;
      base_q   <= burst.base_addr;
      line_buf <= burst.line_out;
    end else if (resp_go) begin
      line_buf <= {mem_resp_data, line_buf[$bits(cache_pkg::line_t)-1:cache_pkg::WORD_BITS]};
    end
  end

  assign mem_req_write = (op_q == mem_msg_pkg::WRITE);
  assign mem_req_addr  = {base_q[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS], beat, 2'b00};
  assign mem_req_data  = line_buf[cache_pkg::WORD_BITS-1:0];
  assign burst.line_in = line_buf;

endmodule

`default_nettype wire

// ==== source/data_store.sv ====
/* Line storage for both ways. Writes take a whole refill line or one word,
   reads register the selected word and the whole line one cycle later */
`timescale 1ns/1ps
`default_nettype none

module data_store (
  input  logic             clk,
  cache_ctrl_if.data       ctrl,
  input  cache_pkg::line_t line_in
);

  cache_pkg::line_t lines [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
  cache_pkg::line_t cur_line;

  assign cur_line = lines[ctrl.way][ctrl.index];

  // Writes into the recorded way
  always_ff @(posedge clk) begin
    if (ctrl.line_write)
      lines[ctrl.way][ctrl.index] <= line_in;
    else if (ctrl.word_write)
      lines[ctrl.way][ctrl.index][ctrl.word_sel*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS]
        <= ctrl.write_word;
  end

  // Read registers hold until the next read_en
  always_ff @(posedge clk) begin
    if (ctrl.read_en) begin
      ctrl.read_line <= cur_line;
      ctrl.read_word <= cur_line[ctrl.word_sel*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS];
    end
  end

endmodule

`default_nettype wire

// ==== source/tag_store.sv ====
/* Tag, NS, valid, dirty and LRU state. The LRU bit of a set names the way
   to replace next. A tag match with the wrong NS bit is a false hit */
`timescale 1ns/1ps
`default_nettype none

module tag_store (
  input  logic       clk,
  input  logic       reset,
  cache_ctrl_if.tags ctrl
);

  cache_pkg::tag_t tags    [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
  logic            ns_bits [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

  logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] valid;
  logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] dirty;
  logic [cache_pkg::NUM_SETS-1:0]                          lru;

  logic [cache_pkg::NUM_WAYS-1:0] tag_match;
  logic [cache_pkg::NUM_WAYS-1:0] way_hit;
  logic [cache_pkg::NUM_WAYS-1:0] way_false;
  cache_pkg::way_t                lru_way;

  assign lru_way = lru[ctrl.index];

  // Both ways compared in parallel
  always_comb begin
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      tag_match[w] = valid[w][ctrl.index] && (tags[w][ctrl.index] == ctrl.tag);
      way_hit[w]   = tag_match[w] && (ns_bits[w][ctrl.index] == ctrl.ns);
      way_false[w] = tag_match[w] && (ns_bits[w][ctrl.index] != ctrl.ns);
    end
  end

  // ------------------------------
  // Control bits and lookup status
  always_ff @(posedge clk) begin
    if (reset) begin
      valid             <= '0;
      dirty             <= '0;
      lru               <= '0;
      ctrl.hit          <= 1'b0;
      ctrl.false_hit    <= 1'b0;
      ctrl.hit_way      <= 1'b0;
      ctrl.victim_way   <= 1'b0;
      ctrl.victim_dirty <= 1'b0;
    end else begin
      if (ctrl.tag_check) begin
        ctrl.hit          <= |way_hit;
        ctrl.false_hit    <= |way_false && !(|way_hit);
        ctrl.hit_way      <= way_hit[1];
        ctrl.victim_way   <= lru_way;
        ctrl.victim_dirty <= valid[lru_way][ctrl.index] && dirty[lru_way][ctrl.index];
      end
      if (ctrl.line_install) begin
        valid[ctrl.way][ctrl.index] <= 1'b1;
        dirty[ctrl.way][ctrl.index] <= 1'b0;
      end
      if (ctrl.word_write) dirty[ctrl.way][ctrl.index] <= 1'b1;
      // Point the set away from the way just used
      if (ctrl.touch) lru[ctrl.index] <= ~ctrl.way;
    end
  end

  // Tag and NS payload
  always_ff @(posedge clk) begin
    if (ctrl.tag_check) ctrl.victim_tag <= tags[lru_way][ctrl.index];
    if (ctrl.line_install) begin
      tags[ctrl.way][ctrl.index]    <= ctrl.tag;
      ns_bits[ctrl.way][ctrl.index] <= ctrl.ns;
    end
  end

endmodule

`default_nettype wire

// ==== source/cache_fsm.sv ====
/* Blocking controller, one request in flight. A hit or false hit responds
   3 cycles after acceptance, a miss takes as long as the memory bursts do */
`timescale 1ns/1ps
`default_nettype none

module cache_fsm (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  input  logic              req_write,
  input  logic              req_ns,
  input  cache_pkg::addr_t  req_addr,
  input  cache_pkg::word_t  req_data,
  output logic              req_rdy,
  output logic              resp_val,
  input  logic              resp_rdy,
  output cache_pkg::word_t  resp_data,
  output logic              resp_denied,
  cache_ctrl_if.fsm         ctrl,
  burst_if.fsm              burst
);

  cache_pkg::cache_state_e state;
  cache_pkg::cache_state_e state_next;
  cache_pkg::cache_state_e access_state;

  cache_pkg::addr_t addr_q;
  cache_pkg::word_t data_q;
  logic             write_q;
  logic             ns_q;
  cache_pkg::way_t  way_q;

  // Set once the pulse of the current state has gone out
  logic pending;
  logic resp_read;
  logic resp_deny;
  logic accept;
  logic tag_check_p;
  logic start_p;

  assign accept       = req_val && req_rdy;
  assign access_state = write_q ? cache_pkg::WRITE_ACCESS : cache_pkg::READ_ACCESS;

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_next = state;
    unique case (state)
      cache_pkg::IDLE:
        if (req_val) state_next = cache_pkg::TAG_CHECK;
      cache_pkg::TAG_CHECK:
        // Second cycle, lookup status is in
        if (pending) begin
          if (ctrl.hit) state_next = access_state;
          else if (ctrl.false_hit) state_next = cache_pkg::DENY;
          else if (ctrl.victim_dirty) state_next = cache_pkg::EVICT_PREPARE;
          else state_next = cache_pkg::REFILL;
        end
      cache_pkg::READ_ACCESS, cache_pkg::WRITE_ACCESS, cache_pkg::DENY:
        state_next = cache_pkg::WAIT;
      cache_pkg::EVICT_PREPARE:
        state_next = cache_pkg::EVICT;
      cache_pkg::EVICT:
        if (burst.done) state_next = cache_pkg::REFILL;
      cache_pkg::REFILL:
        if (burst.done) state_next = burst.fail ? cache_pkg::DENY : cache_pkg::REFILL_UPDATE;
      cache_pkg::REFILL_UPDATE:
        state_next = access_state;
      cache_pkg::WAIT:
        if (resp_rdy) state_next = cache_pkg::IDLE;
      default:
        state_next = cache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= cache_pkg::IDLE;
      pending   <= 1'b0;
      way_q     <= 1'b0;
      resp_read <= 1'b0;
      resp_deny <= 1'b0;
    end else begin
      state <= state_next;
      if (state_next != state) pending <= 1'b0;
      else if (tag_check_p || start_p) pending <= 1'b1;
      // Hit way, or the LRU way to fill on a miss
      if (state == cache_pkg::TAG_CHECK && pending)
        way_q <= ctrl.hit ? ctrl.hit_way : ctrl.victim_way;
      if (accept) begin
        resp_read <= 1'b0;
        resp_deny <= 1'b0;
      end
      if (state == cache_pkg::READ_ACCESS) resp_read <= 1'b1;
      if (state == cache_pkg::DENY) resp_deny <= 1'b1;
    end
  end

  // Request capture
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= req_addr;
      data_q  <= req_data;
      write_q <= req_write;
      ns_q    <= req_ns;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  assign tag_check_p = (state == cache_pkg::TAG_CHECK) && !pending;
  assign start_p     = (state == cache_pkg::EVICT || state == cache_pkg::REFILL) && !pending;

  assign req_rdy     = (state == cache_pkg::IDLE);
  assign resp_val    = (state == cache_pkg::WAIT);
  assign resp_denied = resp_deny;
  // Read word stays put in the data store until the next read
  assign resp_data   = resp_read ? ctrl.read_word : '0;

  assign ctrl.index        = addr_q[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];
  assign ctrl.tag          = addr_q[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
  assign ctrl.ns           = ns_q;
  assign ctrl.word_sel     = addr_q[cache_pkg::OFFSET_BITS-1:2];
  assign ctrl.write_word   = data_q;
  assign ctrl.tag_check    = tag_check_p;
  assign ctrl.way          = way_q;
  assign ctrl.line_install = (state == cache_pkg::REFILL_UPDATE);
  assign ctrl.line_write   = (state == cache_pkg::REFILL_UPDATE);
  assign ctrl.word_write   = (state == cache_pkg::WRITE_ACCESS);
  assign ctrl.touch        = (state == cache_pkg::READ_ACCESS) ||
                             (state == cache_pkg::WRITE_ACCESS);
  assign ctrl.read_en      = (state == cache_pkg::READ_ACCESS) ||
                             (state == cache_pkg::EVICT_PREPARE);

  assign burst.start     = start_p;
  assign burst.op        = (state == cache_pkg::EVICT) ? mem_msg_pkg::WRITE : mem_msg_pkg::READ;
  assign burst.base_addr = (state == cache_pkg::EVICT) ?
                           {ctrl.victim_tag, ctrl.index, {cache_pkg::OFFSET_BITS{1'b0}}} :
                           {addr_q[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS],
                            {cache_pkg::OFFSET_BITS{1'b0}}};
  assign burst.line_out  = ctrl.read_line;

endmodule

`default_nettype wire

// ==== source/burst_if.sv ====
/* Controller to line burst unit. start and done are single-cycle pulses,
   fail is only meaningful together with done */
`timescale 1ns/1ps
`default_nettype none

interface burst_if;

  // Command side
  logic                 start;
  mem_msg_pkg::mem_op_e op;
  cache_pkg::addr_t     base_addr;
  cache_pkg::line_t     line_out;

  // Completion side
  logic                 done;
  logic                 fail;
  cache_pkg::line_t     line_in;

  modport fsm (
    output start, op, base_addr, line_out,
    input  done, fail
  );

  modport burst (
    input  start, op, base_addr, line_out,
    output done, fail, line_in
  );

endinterface

`default_nettype wire

// ==== source/cache_ctrl_if.sv ====
/* Controller commands to tag and data stores, status back.
   Lookup status is valid the cycle after tag_check and held until the next one */
`timescale 1ns/1ps
`default_nettype none

interface cache_ctrl_if;

  // Request fields and commands from the controller
  cache_pkg::index_t    index;
  cache_pkg::tag_t      tag;
  logic                 ns;
  cache_pkg::word_sel_t word_sel;
  cache_pkg::word_t     write_word;
  logic                 tag_check;
  cache_pkg::way_t      way;
  logic                 line_install;
  logic                 line_write;
  logic                 word_write;
  logic                 touch;
  logic                 read_en;

  // Lookup status
  logic                 hit;
  logic                 false_hit;
  cache_pkg::way_t      hit_way;
  cache_pkg::way_t      victim_way;
  logic                 victim_dirty;
  cache_pkg::tag_t      victim_tag;

  // Registered read data
  cache_pkg::word_t     read_word;
  cache_pkg::line_t     read_line;

  modport fsm (
    output index, tag, ns, word_sel, write_word, tag_check, way,
           line_install, line_write, word_write, touch, read_en,
    input  hit, false_hit, hit_way, victim_way, victim_dirty, victim_tag,
           read_word, read_line
  );

  modport tags (
    input  index, tag, ns, tag_check, way, line_install, word_write, touch,
    output hit, false_hit, hit_way, victim_way, victim_dirty, victim_tag
  );

  modport data (
    input  index, word_sel, write_word, way, line_write, word_write, read_en,
    output read_word, read_line
  );

endinterface

`default_nettype wire

// ==== source/mem_msg_pkg.sv ====
/* Memory side message kinds. A line moves as four word beats */
`default_nettype none

package mem_msg_pkg;

  // Operation carried by mem_req_write
  typedef enum logic {
    READ  = 1'b0,
    WRITE = 1'b1
  } mem_op_e;

  // ------------------------------
  // Burst shape
  localparam int BURST_BEATS = 4;

  typedef logic [$clog2(BURST_BEATS)-1:0] beat_t;

endpackage

`default_nettype wire

// ==== source/cache_pkg.sv ====
/* Geometry of the two-way, eight-set data cache with 16-byte lines.
   Byte address splits as tag[31:7], index[6:4], word[3:2], byte[1:0] */
`default_nettype none

package cache_pkg;

  // ------------------------------
  // Geometry
  localparam int WORD_BITS   = 32;
  localparam int ADDR_BITS   = 32;
  localparam int LINE_WORDS  = 4;
  localparam int NUM_SETS    = 8;
  localparam int NUM_WAYS    = 2;
  localparam int OFFSET_BITS = 4;
  localparam int INDEX_BITS  = $clog2(NUM_SETS);
  localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

  typedef logic [ADDR_BITS-1:0]            addr_t;
  typedef logic [WORD_BITS-1:0]            word_t;
  typedef logic [LINE_WORDS*WORD_BITS-1:0] line_t;
  typedef logic [TAG_BITS-1:0]             tag_t;
  typedef logic [INDEX_BITS-1:0]           index_t;
  typedef logic [1:0]                      word_sel_t;
  typedef logic                            way_t;

  // Controller states
  typedef enum logic [3:0] {
    IDLE, TAG_CHECK, READ_ACCESS, WRITE_ACCESS, EVICT_PREPARE,
    EVICT, REFILL, REFILL_UPDATE, DENY, WAIT
  } cache_state_e;

endpackage

`default_nettype wire
